// ==== compile.f ====
+incdir+include
logic/conv_data_pkg.sv
logic/conv_ctrl_pkg.sv
logic/window_buffer.sv
logic/kernel_mac_array.sv
logic/frame_controller.sv
logic/conv_engine_2d.sv
testbench/conv_engine_2d_sva.sv
testbench/conv_engine_2d_tb.sv

// ==== include/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Frame geometry in pixels
`define CONV_IMG_WIDTH 32
`define CONV_IMG_HEIGHT 32

// Side of the square convolution window
`define CONV_KERNEL_SIZE 3

// Clock edges from the edge that accepts a pixel to its valid result.
// One edge for the window register, one for the products and
// three more for the adder tree after the first partial sums
`define CONV_RESULT_LATENCY 5

`endif

// ==== logic/conv_ctrl_pkg.sv ====
`include "conv_config.svh"

package conv_ctrl_pkg;

	typedef logic [$clog2(`CONV_IMG_WIDTH)-1:0] col_t;
	typedef logic [$clog2(`CONV_IMG_HEIGHT)-1:0] row_t;

	// DONE lasts a single cycle before the engine drops back to IDLE
	typedef enum logic [1:0] {
		IDLE,
		PROCESSING,
		DONE
	} frame_state_e;

endpackage

// ==== logic/conv_data_pkg.sv ====
`include "conv_config.svh"

package conv_data_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;

	// Product of a zero-extended pixel and one coefficient
	typedef logic signed [17:0] product_t;

	// Partial sums grow by one bit at each adder tree stage
	typedef logic signed [18:0] stage1_sum_t;
	typedef logic signed [19:0] stage2_sum_t;
	typedef logic signed [20:0] stage3_sum_t;

	typedef logic signed [21:0] result_t;

	// Horizontal Sobel operator, row 0 is the oldest image row
	localparam weight_t sobel_x_kernel [0:`CONV_KERNEL_SIZE-1][0:`CONV_KERNEL_SIZE-1] = '{
		'{8'sd1, 8'sd0, -8'sd1},
		'{8'sd2, 8'sd0, -8'sd2},
		'{8'sd1, 8'sd0, -8'sd1}
	};

endpackage

// ==== logic/conv_engine_2d.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_engine_2d (
	input  logic clk,
	input  logic rst,
	input  logic start_signal,
	input  logic pixel_valid,
	input  conv_data_pkg::pixel_t pixel_in,
	output conv_data_pkg::result_t result_out,
	output logic result_valid,
	output logic done_signal
);

	logic pixel_accept;
	logic window_valid;

	conv_data_pkg::pixel_t window_00;
	conv_data_pkg::pixel_t window_01;
	conv_data_pkg::pixel_t window_02;
	conv_data_pkg::pixel_t window_10;
	conv_data_pkg::pixel_t window_11;
	conv_data_pkg::pixel_t window_12;
	conv_data_pkg::pixel_t window_20;
	conv_data_pkg::pixel_t window_21;
	conv_data_pkg::pixel_t window_22;

	frame_controller u_frame_controller (
		.clk          (clk),
		.rst          (rst),
		.start_signal (start_signal),
		.pixel_valid  (pixel_valid),
		.pixel_accept (pixel_accept),
		.window_valid (window_valid),
		.done_signal  (done_signal)
	);

	window_buffer u_window_buffer (
		.clk          (clk),
		.rst          (rst),
		.pixel_accept (pixel_accept),
		.pixel_in     (pixel_in),
		.window_00    (window_00),
		.window_01    (window_01),
		.window_02    (window_02),
		.window_10    (window_10),
		.window_11    (window_11),
		.window_12    (window_12),
		.window_20    (window_20),
		.window_21    (window_21),
		.window_22    (window_22)
	);

	kernel_mac_array u_kernel_mac_array (
		.clk          (clk),
		.rst          (rst),
		.window_valid (window_valid),
		.window_00    (window_00),
		.window_01    (window_01),
		.window_02    (window_02),
		.window_10    (window_10),
		.window_11    (window_11),
		.window_12    (window_12),
		.window_20    (window_20),
		.window_21    (window_21),
		.window_22    (window_22),
		.result_out   (result_out),
		.result_valid (result_valid)
	);

endmodule

// ==== logic/frame_controller.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module frame_controller (
	input  logic clk,
	input  logic rst,
	input  logic start_signal,
	input  logic pixel_valid,
	output logic pixel_accept,
	output logic window_valid,
	output logic done_signal
);

	localparam conv_ctrl_pkg::col_t LAST_COL = conv_ctrl_pkg::col_t'(`CONV_IMG_WIDTH - 1);
	localparam conv_ctrl_pkg::row_t LAST_ROW = conv_ctrl_pkg::row_t'(`CONV_IMG_HEIGHT - 1);
	localparam conv_ctrl_pkg::col_t FIRST_COL = conv_ctrl_pkg::col_t'(`CONV_KERNEL_SIZE - 1);
	localparam conv_ctrl_pkg::row_t FIRST_ROW = conv_ctrl_pkg::row_t'(`CONV_KERNEL_SIZE - 1);

	conv_ctrl_pkg::frame_state_e state;
	conv_ctrl_pkg::frame_state_e next_state;
	conv_ctrl_pkg::col_t col;
	conv_ctrl_pkg::row_t row;

	logic last_pixel;

	assign pixel_accept = pixel_valid && (state == conv_ctrl_pkg::PROCESSING);
	assign last_pixel = (col == LAST_COL) && (row == LAST_ROW);

	always_comb begin
		next_state = state;
		case (state)
			conv_ctrl_pkg::IDLE: if (start_signal) next_state = conv_ctrl_pkg::PROCESSING;
			conv_ctrl_pkg::PROCESSING: if (pixel_accept && last_pixel) next_state = conv_ctrl_pkg::DONE;
			conv_ctrl_pkg::DONE: next_state = conv_ctrl_pkg::IDLE;
			default: next_state = conv_ctrl_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= conv_ctrl_pkg::IDLE;
			col <= '0;
			row <= '0;
			window_valid <= 1'b0;
		end else begin
			state <= next_state;
			// A window is complete once two full rows and two columns are in
			window_valid <= pixel_accept && (col >= FIRST_COL) && (row >= FIRST_ROW);
			if (state == conv_ctrl_pkg::IDLE) begin
				col <= '0;
				row <= '0;
			end else if (pixel_accept) begin
				if (col == LAST_COL) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign done_signal = (state == conv_ctrl_pkg::DONE);

endmodule

// ==== logic/kernel_mac_array.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module kernel_mac_array (
	input  logic clk,
	input  logic rst,
	input  logic window_valid,
	input  conv_data_pkg::pixel_t window_00,
	input  conv_data_pkg::pixel_t window_01,
	input  conv_data_pkg::pixel_t window_02,
	input  conv_data_pkg::pixel_t window_10,
	input  conv_data_pkg::pixel_t window_11,
	input  conv_data_pkg::pixel_t window_12,
	input  conv_data_pkg::pixel_t window_20,
	input  conv_data_pkg::pixel_t window_21,
	input  conv_data_pkg::pixel_t window_22,
	output conv_data_pkg::result_t result_out,
	output logic result_valid
);

	localparam int K = `CONV_KERNEL_SIZE;
	localparam int TAPS = K * K;
	localparam int LAT = `CONV_RESULT_LATENCY;

	conv_data_pkg::pixel_t win [0:K-1][0:K-1];

	// Products are kept flat in row-major tap order
	conv_data_pkg::product_t prod [0:TAPS-1];

	conv_data_pkg::stage1_sum_t sum1 [0:4];
	conv_data_pkg::stage2_sum_t sum2 [0:2];
	conv_data_pkg::stage3_sum_t sum3 [0:1];
	conv_data_pkg::result_t sum_final;

	logic [LAT-1:0] valid_pipe;

	assign win = '{
		'{window_00, window_01, window_02},
		'{window_10, window_11, window_12},
		'{window_20, window_21, window_22}
	};

	// Pixels are unsigned, so the cast to the signed product type zero-extends them
	always_ff @(posedge clk) begin
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K; c++) begin
				prod[r*K+c] <= conv_data_pkg::product_t'(win[r][c])
					* conv_data_pkg::product_t'(conv_data_pkg::sobel_x_kernel[r][c]);
			end
		end
	end

	// Nine products reduce as 5, 3, 2 and then 1 partial sums
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			sum1[i] <= conv_data_pkg::stage1_sum_t'(prod[2*i])
				+ conv_data_pkg::stage1_sum_t'(prod[2*i+1]);
		end
		sum1[4] <= conv_data_pkg::stage1_sum_t'(prod[8]);

		sum2[0] <= conv_data_pkg::stage2_sum_t'(sum1[0])
			+ conv_data_pkg::stage2_sum_t'(sum1[1]);
		sum2[1] <= conv_data_pkg::stage2_sum_t'(sum1[2])
			+ conv_data_pkg::stage2_sum_t'(sum1[3]);
		sum2[2] <= conv_data_pkg::stage2_sum_t'(sum1[4]);

		sum3[0] <= conv_data_pkg::stage3_sum_t'(sum2[0])
			+ conv_data_pkg::stage3_sum_t'(sum2[1]);
		sum3[1] <= conv_data_pkg::stage3_sum_t'(sum2[2]);

		sum_final <= conv_data_pkg::result_t'(sum3[0])
			+ conv_data_pkg::result_t'(sum3[1]);
	end

	// The tag walks alongside the data, one bit per registered stage
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[LAT-2:0], window_valid};
		end
	end

	assign result_out = sum_final;
	assign result_valid = valid_pipe[LAT-1];

endmodule

// ==== logic/window_buffer.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module window_buffer (
	input  logic clk,
	input  logic rst,
	input  logic pixel_accept,
	input  conv_data_pkg::pixel_t pixel_in,
	output conv_data_pkg::pixel_t window_00,
	output conv_data_pkg::pixel_t window_01,
	output conv_data_pkg::pixel_t window_02,
	output conv_data_pkg::pixel_t window_10,
	output conv_data_pkg::pixel_t window_11,
	output conv_data_pkg::pixel_t window_12,
	output conv_data_pkg::pixel_t window_20,
	output conv_data_pkg::pixel_t window_21,
	output conv_data_pkg::pixel_t window_22
);

	localparam int W = `CONV_IMG_WIDTH;
	localparam int K = `CONV_KERNEL_SIZE;

	// Entry i of a line holds the pixel accepted i+1 pixels before it
	conv_data_pkg::pixel_t line_one [0:W-1];
	conv_data_pkg::pixel_t line_two [0:W-1];
	conv_data_pkg::pixel_t win [0:K-1][0:K-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			line_one <= '{default: '0};
			line_two <= '{default: '0};
			win <= '{default: '0};
		end else if (pixel_accept) begin
			// Line two continues where line one ends, so its tail is two rows up
			line_one[0] <= pixel_in;
			line_two[0] <= line_one[W-1];
			for (int i = 1; i < W; i++) begin
				line_one[i] <= line_one[i-1];
				line_two[i] <= line_two[i-1];
			end

			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 1; c++) begin
					win[r][c] <= win[r][c+1];
				end
			end

			// Newest column enters on the right
			win[0][K-1] <= line_two[W-1];
			win[1][K-1] <= line_one[W-1];
			win[2][K-1] <= pixel_in;
		end
	end

	assign window_00 = win[0][0];
	assign window_01 = win[0][1];
	assign window_02 = win[0][2];
	assign window_10 = win[1][0];
	assign window_11 = win[1][1];
	assign window_12 = win[1][2];
	assign window_20 = win[2][0];
	assign window_21 = win[2][1];
	assign window_22 = win[2][2];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f \
	--top-module conv_engine_2d_tb \
	-Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vconv_engine_2d_tb" | tee "$LOG_FILE"

if grep -q "^Test OK$" "$LOG_FILE"; then
	exit 0
else
	echo "Simulation did not pass, see $LOG_FILE"
	exit 1
fi

// ==== testbench/conv_engine_2d_sva.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_engine_2d_sva (
	input logic clk,
	input logic rst,
	input logic start_signal,
	input logic done_signal,
	input logic result_valid,
	input logic window_valid,
	input logic pixel_accept,
	input conv_ctrl_pkg::frame_state_e state
);

	// The DONE state lasts exactly one cycle
	property done_single_cycle;
		@(posedge clk) disable iff (rst)
		done_signal |=> !done_signal;
	endproperty

	// Every result traces back to a complete window through the datapath stages
	property result_follows_window;
		@(posedge clk) disable iff (rst)
		result_valid |-> $past(window_valid, `CONV_RESULT_LATENCY);
	endproperty

	// The first pixel of a frame can only come right after a start pulse left IDLE
	property accept_only_processing;
		@(posedge clk) disable iff (rst)
		(pixel_accept && ($past(state) != conv_ctrl_pkg::PROCESSING)) |-> $past(start_signal);
	endproperty

	assert property (done_single_cycle)
		else $error("done_signal stayed high for more than one cycle");

	assert property (result_follows_window)
		else $error("result_valid without a window_valid five edges earlier");

	assert property (accept_only_processing)
		else $error("pixel_accept high without a start pulse arming the frame");

endmodule

bind conv_engine_2d conv_engine_2d_sva u_conv_engine_2d_sva (
	.clk          (clk),
	.rst          (rst),
	.start_signal (start_signal),
	.done_signal  (done_signal),
	.result_valid (result_valid),
	.window_valid (window_valid),
	.pixel_accept (pixel_accept),
	.state        (u_frame_controller.state)
);

// ==== testbench/conv_engine_2d_tb.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_engine_2d_tb;

	localparam int W = `CONV_IMG_WIDTH;
	localparam int H = `CONV_IMG_HEIGHT;
	localparam int K = `CONV_KERNEL_SIZE;
	localparam int PIXELS = W * H;
	localparam int RESULTS = (W - K + 1) * (H - K + 1);
	localparam int TIMEOUT_CYCLES = 10000;
	localparam int DRAIN_CYCLES = 2 * `CONV_RESULT_LATENCY + 4;

	logic clk;
	logic rst;
	logic start_signal;
	logic pixel_valid;
	conv_data_pkg::pixel_t pixel_in;
	conv_data_pkg::result_t result_out;
	logic result_valid;
	logic done_signal;

	conv_data_pkg::pixel_t frame [0:PIXELS-1];
	conv_data_pkg::result_t expected_q [$];

	int result_count = 0;
	int done_count = 0;
	int value_errors = 0;
	int other_errors = 0;

	conv_engine_2d u_conv_engine_2d (
		.clk          (clk),
		.rst          (rst),
		.start_signal (start_signal),
		.pixel_valid  (pixel_valid),
		.pixel_in     (pixel_in),
		.result_out   (result_out),
		.result_valid (result_valid),
		.done_signal  (done_signal)
	);

	always #20 clk = ~clk;

	task automatic check_result(input conv_data_pkg::result_t expected,
		input conv_data_pkg::result_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED result_out: expected %h, got %h", expected, actual);
		end
	endtask

	task automatic check_flag(input logic expected, input logic actual, input string name);
		if (actual !== expected) begin
			value_errors++;
			$display("FAILED %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic expect_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			other_errors++;
			$display("ERROR: expected %0d %s but counted %0d", expected, what, actual);
		end
	endtask

	// Outputs are sampled mid-cycle, well away from the rising edge
	always @(negedge clk) begin
		if (!rst) begin
			if (result_valid === 1'b1) begin
				result_count++;
				if (expected_q.size() == 0) begin
					other_errors++;
					$display("ERROR: result %h arrived when no result was expected", result_out);
				end else begin
					check_result(expected_q.pop_front(), result_out);
				end
			end
			if (done_signal === 1'b1) begin
				done_count++;
			end
		end
	end

	// Reference model built straight from the window mapping
	task automatic compute_expected();
		int acc;
		for (int y = K - 1; y < H; y++) begin
			for (int x = K - 1; x < W; x++) begin
				acc = 0;
				for (int r = 0; r < K; r++) begin
					for (int c = 0; c < K; c++) begin
						acc += int'(conv_data_pkg::sobel_x_kernel[r][c])
							* int'(frame[(y - K + 1 + r) * W + (x - K + 1 + c)]);
					end
				end
				expected_q.push_back(conv_data_pkg::result_t'(acc));
			end
		end
	endtask

	// Kind 0 is random, the others are stripe and edge patterns
	task automatic fill_frame(input int kind);
		int x;
		for (int i = 0; i < PIXELS; i++) begin
			x = i % W;
			case (kind)
				1: frame[i] = (x % 2 == 1) ? 8'hff : 8'h00;
				2: frame[i] = ((x / 2) % 2 == 1) ? 8'hff : 8'h00;
				3: frame[i] = (x < W / 2) ? 8'h00 : 8'hff;
				4: frame[i] = (x < W / 2) ? 8'hff : 8'h00;
				default: frame[i] = conv_data_pkg::pixel_t'($urandom);
			endcase
		end
	endtask

	task automatic start_frame();
		start_signal = 1'b1;
		@(posedge clk);
		#2;
		start_signal = 1'b0;
	endtask

	// A start pulse rides along with pixel start_at, if it is not negative
	task automatic stream_frame(input int max_gap, input int start_at);
		int gap;
		for (int i = 0; i < PIXELS; i++) begin
			gap = int'($urandom_range(max_gap, 0));
			repeat (gap) begin
				pixel_in = conv_data_pkg::pixel_t'($urandom);
				@(posedge clk);
				#2;
			end
			pixel_valid = 1'b1;
			pixel_in = frame[i];
			start_signal = (i == start_at);
			@(posedge clk);
			#2;
			pixel_valid = 1'b0;
			start_signal = 1'b0;
		end
	endtask

	task automatic wait_for_done(input int target, input string what);
		int cycles;
		cycles = 0;
		while (done_count < target && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (done_count < target) begin
			other_errors++;
			$display("ERROR: no done pulse within %0d cycles in %s", TIMEOUT_CYCLES, what);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic wait_for_results(input int target, input string what);
		int cycles;
		cycles = 0;
		while (result_count < target && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (result_count < target) begin
			other_errors++;
			$display("ERROR: only %0d of %0d results arrived within %0d cycles in %s",
				result_count, target, TIMEOUT_CYCLES, what);
		end
		// Extra results would show up here as unexpected arrivals
		repeat (DRAIN_CYCLES) @(negedge clk);
		expect_count("results in total", target, result_count);
		if (expected_q.size() != 0) begin
			other_errors++;
			$display("ERROR: %0d expected results never arrived in %s", expected_q.size(), what);
			expected_q.delete();
		end
		@(posedge clk);
		#2;
	endtask

	task automatic run_single_frame(input string what, input int max_gap);
		int base_results;
		int base_done;
		base_results = result_count;
		base_done = done_count;
		compute_expected();
		start_frame();
		stream_frame(max_gap, -1);
		wait_for_done(base_done + 1, what);
		wait_for_results(base_results + RESULTS, what);
		expect_count("done pulses for one frame", 1, done_count - base_done);
	endtask

	task automatic test_reset_state();
		int base_results;
		int base_done;
		base_results = result_count;
		base_done = done_count;
		for (int i = 0; i < 8; i++) begin
			pixel_valid = (i % 2 == 0);
			pixel_in = conv_data_pkg::pixel_t'($urandom);
			@(negedge clk);
			check_flag(1'b0, result_valid, "result_valid");
			check_flag(1'b0, done_signal, "done_signal");
			@(posedge clk);
			#2;
		end
		pixel_valid = 1'b0;
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			check_flag(1'b0, result_valid, "result_valid");
			check_flag(1'b0, done_signal, "done_signal");
		end
		@(posedge clk);
		#2;
		expect_count("results while idle", 0, result_count - base_results);
		expect_count("done pulses while idle", 0, done_count - base_done);
	endtask

	task automatic test_full_frame();
		fill_frame(0);
		run_single_frame("full frame test", 0);
	endtask

	// Reuses the frame of the previous test
	task automatic test_gapped_stream();
		run_single_frame("gapped stream test", 3);
	endtask

	task automatic test_extreme_values();
		for (int kind = 1; kind <= 4; kind++) begin
			fill_frame(kind);
			run_single_frame("extreme values test", 0);
		end
	endtask

	task automatic test_back_to_back_frames();
		int base_results;
		int base_done;
		base_results = result_count;
		base_done = done_count;
		fill_frame(0);
		compute_expected();
		start_frame();
		stream_frame(0, PIXELS / 2);
		wait_for_done(base_done + 1, "first of two frames");
		fill_frame(0);
		compute_expected();
		start_frame();
		stream_frame(1, -1);
		wait_for_done(base_done + 2, "second of two frames");
		wait_for_results(base_results + 2 * RESULTS, "back to back frames test");
		expect_count("done pulses for two frames", 2, done_count - base_done);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start_signal = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		void'($urandom(32'h13c4_34cb));
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		test_reset_state();
		test_full_frame();
		test_gapped_stream();
		test_extreme_values();
		test_back_to_back_frames();

		$display("Summary: %0d value mismatches, %0d other errors, %0d results, %0d done pulses",
			value_errors, other_errors, result_count, done_count);
		if (value_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
